// File: audio_spi_regs.f
+incdir+rtl
rtl/audio_spi_pkg.sv
rtl/spi_bus_if.sv
rtl/spi_slave.sv
rtl/reg_bank.sv
rtl/irq_capture.sv
rtl/audio_spi_top.sv
test/tb_clk_gen.sv
test/tb_audio_spi_top.sv

// File: rtl/audio_spi_cfg.svh
`ifndef AUDIO_SPI_CFG_SVH
`define AUDIO_SPI_CFG_SVH

////////////////////////////////////////////////////////////
// register map, 7-bit addresses
////////////////////////////////////////////////////////////
`define ADDR_AUD_CONTROL    7'h00   // audio control
`define ADDR_AUD_STATUS     7'h01   // audio status, read only
`define ADDR_COEFS_PER_TAP  7'h02
`define ADDR_COEF_SEL       7'h03   // fir filter select
`define ADDR_FIR_COEF_LSB   7'h04   // write last, commits the coefficient
`define ADDR_FIR_COEF_MSB   7'h05
`define ADDR_SRAM_CONTROL   7'h07   // sram page
`define ADDR_SRAM_ADDR      7'h08   // sram start address
`define ADDR_SPI_TO_SRAM    7'h09
`define ADDR_SRAM_TO_SPI    7'h0a   // read only
`define ADDR_MPIO_CONTROL   7'h0b   // mpio select and direction
`define ADDR_SPI_TO_MPIO    7'h0c
`define ADDR_MPIO_TO_SPI    7'h0d   // read only
`define ADDR_EQ_SEL         7'h0e   // equalizer channel
`define ADDR_EQ_GAIN_LSB    7'h0f   // write last, commits the gain
`define ADDR_EQ_GAIN_MSB    7'h10
`define ADDR_STATUS         7'h11   // irq flag on top of external status
`define ADDR_TEST           7'h12   // scratch
`define ADDR_INTERRUPT      7'h13   // cleared by a read
`define ADDR_I2S_BIT_CNT    7'h14   // read only
`define ADDR_EQ_SCALER_LSB  7'h17
`define ADDR_EQ_SCALER_MSB  7'h18
`define ADDR_ROTARY         7'h19   // encoder clicks, read only

`define UNMAPPED_READ       8'h99   // returned for holes in the map
`define SPI_FRAME_BITS      16      // r/w + addr byte, then data byte

`endif

// File: rtl/audio_spi_pkg.sv
`default_nettype none

package audio_spi_pkg;

    typedef logic [7:0] reg_data_t;     // register or data byte
    typedef logic [6:0] reg_addr_t;     // register address
    typedef logic [6:0] status_bits_t;  // external status, bit 7 is the irq flag

    // spi slave frame sequencer
    typedef enum logic [1:0] {
        IDLE, // cs_n high
        ADDR, // r/w bit + address
        DATA, // data byte in or out
        DONE  // wait for cs_n to rise
    } spi_state_t;

endpackage

`default_nettype wire

// File: rtl/audio_spi_top.sv
`timescale 1ns/1ps
`default_nettype none

module audio_spi_top (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    // spi pins
    input  wire logic                         sclk,
    input  wire logic                         cs_n,
    input  wire logic                         mosi,
    output logic                              miso,
    output logic                              miso_oe,     // pad enable
    // register inputs
    input  wire audio_spi_pkg::reg_data_t     audio_status,
    input  wire audio_spi_pkg::reg_data_t     i2s_bit_cnt,
    input  wire audio_spi_pkg::reg_data_t     sram_rd_data,
    input  wire audio_spi_pkg::reg_data_t     mpio_rd_data,
    input  wire audio_spi_pkg::reg_data_t     rotary_count,
    input  wire audio_spi_pkg::status_bits_t  status,
    input  wire audio_spi_pkg::reg_data_t     irq_in,
    // register outputs
    output audio_spi_pkg::reg_data_t          audio_control,
    output audio_spi_pkg::reg_data_t          coefs_per_tap,
    output audio_spi_pkg::reg_data_t          coef_select,
    output audio_spi_pkg::reg_data_t          coef_lsb,
    output audio_spi_pkg::reg_data_t          coef_msb,
    output audio_spi_pkg::reg_data_t          eq_select,
    output audio_spi_pkg::reg_data_t          eq_gain_lsb,
    output audio_spi_pkg::reg_data_t          eq_gain_msb,
    output audio_spi_pkg::reg_data_t          eq_scaler_lsb,
    output audio_spi_pkg::reg_data_t          eq_scaler_msb,
    output audio_spi_pkg::reg_data_t          sram_control,
    output audio_spi_pkg::reg_data_t          sram_start_addr,
    output audio_spi_pkg::reg_data_t          spi_to_sram,
    output audio_spi_pkg::reg_data_t          mpio_control,
    output audio_spi_pkg::reg_data_t          spi_to_mpio,
    output audio_spi_pkg::reg_data_t          test_reg,
    // strobes
    output logic                              coef_wr_stb,
    output logic                              eq_wr_stb,
    output logic                              rotary_rd_stb
);

    logic                     irq_rd_stb;  // bank to irq block
    logic                     irq_flag;
    audio_spi_pkg::reg_data_t irq_held;

    spi_bus_if bus ();

    spi_slave i_spi_slave (
        .clk     (clk),
        .arst_n  (arst_n),
        .sclk    (sclk),
        .cs_n    (cs_n),
        .mosi    (mosi),
        .miso    (miso),
        .miso_oe (miso_oe),
        .bus     (bus.slave)
    );

    // every other port shares its name with a top port or local
    reg_bank i_reg_bank (
        .bus (bus.bank),
        .*
    );

    irq_capture i_irq_capture (
        .clk        (clk),
        .arst_n     (arst_n),
        .irq_rd_stb (irq_rd_stb),
        .irq_in     (irq_in),
        .irq_held   (irq_held),
        .irq_flag   (irq_flag)
    );

endmodule

`default_nettype wire

// File: rtl/irq_capture.sv
`timescale 1ns/1ps
`default_nettype none

module irq_capture (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire logic                      irq_rd_stb,
    input  wire audio_spi_pkg::reg_data_t  irq_in,
    output audio_spi_pkg::reg_data_t       irq_held,
    output logic                           irq_flag
);

    audio_spi_pkg::reg_data_t irq_last;  // irq_in as last sampled

    // a change wins over a read clear in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_last <= '0;
            irq_held <= '0;
            irq_flag <= 1'b0;
        end else begin
            irq_last <= irq_in;
            if (irq_in != irq_last) begin
                irq_held <= irq_in;    // new input state for the host
                irq_flag <= 1'b1;      // shows in status bit 7
            end else if (irq_rd_stb) begin
                irq_held <= '0;        // host has seen it
                irq_flag <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none
`include "audio_spi_cfg.svh"

module reg_bank (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    spi_bus_if.bank                           bus,
    // read-only inputs
    input  wire audio_spi_pkg::reg_data_t     audio_status,
    input  wire audio_spi_pkg::reg_data_t     i2s_bit_cnt,
    input  wire audio_spi_pkg::reg_data_t     sram_rd_data,
    input  wire audio_spi_pkg::reg_data_t     mpio_rd_data,
    input  wire audio_spi_pkg::reg_data_t     rotary_count,
    input  wire audio_spi_pkg::status_bits_t  status,
    input  wire logic                         irq_flag,
    input  wire audio_spi_pkg::reg_data_t     irq_held,
    // read/write registers
    output audio_spi_pkg::reg_data_t          audio_control,
    output audio_spi_pkg::reg_data_t          coefs_per_tap,
    output audio_spi_pkg::reg_data_t          coef_select,
    output audio_spi_pkg::reg_data_t          coef_lsb,
    output audio_spi_pkg::reg_data_t          coef_msb,
    output audio_spi_pkg::reg_data_t          eq_select,
    output audio_spi_pkg::reg_data_t          eq_gain_lsb,
    output audio_spi_pkg::reg_data_t          eq_gain_msb,
    output audio_spi_pkg::reg_data_t          eq_scaler_lsb,
    output audio_spi_pkg::reg_data_t          eq_scaler_msb,
    output audio_spi_pkg::reg_data_t          sram_control,
    output audio_spi_pkg::reg_data_t          sram_start_addr,
    output audio_spi_pkg::reg_data_t          spi_to_sram,
    output audio_spi_pkg::reg_data_t          mpio_control,
    output audio_spi_pkg::reg_data_t          spi_to_mpio,
    output audio_spi_pkg::reg_data_t          test_reg,
    // side-effect strobes
    output logic                              coef_wr_stb,
    output logic                              eq_wr_stb,
    output logic                              rotary_rd_stb,
    output logic                              irq_rd_stb
);

    ////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            audio_control   <= '0;
            coefs_per_tap   <= '0;
            coef_select     <= '0;
            coef_lsb        <= '0;
            coef_msb        <= '0;
            eq_select       <= '0;
            eq_gain_lsb     <= '0;
            eq_gain_msb     <= '0;
            eq_scaler_lsb   <= '0;
            eq_scaler_msb   <= '0;
            sram_control    <= '0;
            sram_start_addr <= '0;
            spi_to_sram     <= '0;
            mpio_control    <= '0;
            spi_to_mpio     <= '0;
            test_reg        <= '0;
        end else if (bus.wr_stb) begin
            case (bus.addr)
                `ADDR_AUD_CONTROL:   audio_control   <= bus.wdata;
                `ADDR_COEFS_PER_TAP: coefs_per_tap   <= bus.wdata;
                `ADDR_COEF_SEL:      coef_select     <= bus.wdata;
                `ADDR_FIR_COEF_LSB:  coef_lsb        <= bus.wdata;
                `ADDR_FIR_COEF_MSB:  coef_msb        <= bus.wdata;
                `ADDR_EQ_SEL:        eq_select       <= bus.wdata;
                `ADDR_EQ_GAIN_LSB:   eq_gain_lsb     <= bus.wdata;
                `ADDR_EQ_GAIN_MSB:   eq_gain_msb     <= bus.wdata;
                `ADDR_EQ_SCALER_LSB: eq_scaler_lsb   <= bus.wdata;
                `ADDR_EQ_SCALER_MSB: eq_scaler_msb   <= bus.wdata;
                `ADDR_SRAM_CONTROL:  sram_control    <= bus.wdata;
                `ADDR_SRAM_ADDR:     sram_start_addr <= bus.wdata;
                `ADDR_SPI_TO_SRAM:   spi_to_sram     <= bus.wdata;
                `ADDR_MPIO_CONTROL:  mpio_control    <= bus.wdata;
                `ADDR_SPI_TO_MPIO:   spi_to_mpio     <= bus.wdata;
                `ADDR_TEST:          test_reg        <= bus.wdata;
                default: ;  // read-only or hole, dropped
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // read mux, held until the next rd_stb
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus.rdata <= '0;
        end else if (bus.rd_stb) begin
            case (bus.addr)
                `ADDR_AUD_CONTROL:   bus.rdata <= audio_control;
                `ADDR_AUD_STATUS:    bus.rdata <= audio_status;
                `ADDR_COEFS_PER_TAP: bus.rdata <= coefs_per_tap;
                `ADDR_COEF_SEL:      bus.rdata <= coef_select;
                `ADDR_FIR_COEF_LSB:  bus.rdata <= coef_lsb;
                `ADDR_FIR_COEF_MSB:  bus.rdata <= coef_msb;
                `ADDR_SRAM_CONTROL:  bus.rdata <= sram_control;
                `ADDR_SRAM_ADDR:     bus.rdata <= sram_start_addr;
                `ADDR_SPI_TO_SRAM:   bus.rdata <= spi_to_sram;
                `ADDR_SRAM_TO_SPI:   bus.rdata <= sram_rd_data;
                `ADDR_MPIO_CONTROL:  bus.rdata <= mpio_control;
                `ADDR_SPI_TO_MPIO:   bus.rdata <= spi_to_mpio;
                `ADDR_MPIO_TO_SPI:   bus.rdata <= mpio_rd_data;
                `ADDR_EQ_SEL:        bus.rdata <= eq_select;
                `ADDR_EQ_GAIN_LSB:   bus.rdata <= eq_gain_lsb;
                `ADDR_EQ_GAIN_MSB:   bus.rdata <= eq_gain_msb;
                `ADDR_STATUS:        bus.rdata <= {irq_flag, status};
                `ADDR_TEST:          bus.rdata <= test_reg;
                `ADDR_INTERRUPT:     bus.rdata <= irq_held;
                `ADDR_I2S_BIT_CNT:   bus.rdata <= i2s_bit_cnt;
                `ADDR_EQ_SCALER_LSB: bus.rdata <= eq_scaler_lsb;
                `ADDR_EQ_SCALER_MSB: bus.rdata <= eq_scaler_msb;
                `ADDR_ROTARY:        bus.rdata <= rotary_count;
                default:             bus.rdata <= `UNMAPPED_READ;
            endcase
        end
    end

    // commit strobes follow the lsb write, msb must already be in place
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            coef_wr_stb <= 1'b0;
            eq_wr_stb   <= 1'b0;
            irq_rd_stb  <= 1'b0;
        end else begin
            coef_wr_stb <= bus.wr_stb && (bus.addr == `ADDR_FIR_COEF_LSB);
            eq_wr_stb   <= bus.wr_stb && (bus.addr == `ADDR_EQ_GAIN_LSB);
            irq_rd_stb  <= bus.rd_stb && (bus.addr == `ADDR_INTERRUPT); // after the load
        end
    end

    assign rotary_rd_stb = bus.rd_stb && (bus.addr == `ADDR_ROTARY); // encoder pops its count

endmodule

`default_nettype wire

// File: rtl/spi_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface spi_bus_if;

    audio_spi_pkg::reg_addr_t addr;   // valid at rd_stb and wr_stb
    audio_spi_pkg::reg_data_t wdata;  // valid at wr_stb
    audio_spi_pkg::reg_data_t rdata;  // loaded the clk after rd_stb
    logic                     rd_stb; // after the address byte of a read
    logic                     wr_stb; // after the data byte of a write

    modport slave (
        output addr, wdata, rd_stb, wr_stb,
        input  rdata
    );

    modport bank (
        input  addr, wdata, rd_stb, wr_stb,
        output rdata
    );

endinterface

`default_nettype wire

// File: rtl/spi_slave.sv
`timescale 1ns/1ps
`default_nettype none
`include "audio_spi_cfg.svh"

module spi_slave (
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  sclk,
    input  wire logic  cs_n,
    input  wire logic  mosi,
    output logic       miso,
    output logic       miso_oe,
    spi_bus_if.slave   bus
);

    localparam int CNT_W = $clog2(`SPI_FRAME_BITS);
    localparam logic [CNT_W-1:0] LAST_ADDR_BIT = CNT_W'(`SPI_FRAME_BITS / 2 - 1);
    localparam logic [CNT_W-1:0] LAST_BIT      = CNT_W'(`SPI_FRAME_BITS - 1);

    logic [1:0]                sclk_sync;
    logic [1:0]                cs_sync;
    logic [1:0]                mosi_sync;
    logic                      sclk_last;  // for edge detect
    logic                      sclk_rise;
    logic                      sclk_fall;
    logic                      cs_active;
    audio_spi_pkg::spi_state_t state;
    logic [CNT_W-1:0]          bit_cnt;    // rising edges seen this frame
    audio_spi_pkg::reg_data_t  rx_sreg;
    audio_spi_pkg::reg_data_t  rx_next;
    audio_spi_pkg::reg_data_t  tx_sreg;
    logic                      is_rd;      // r/w bit of the current frame
    logic                      tx_load;    // next fall loads rdata
    logic                      addr_done;
    logic                      data_done;

    ////////////////////////////////////////////////////////////
    // pin synchronizers and sclk edges
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sclk_sync <= '0;
            cs_sync   <= '1;   // deselected
            mosi_sync <= '0;
            sclk_last <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            cs_sync   <= {cs_sync[0], cs_n};
            mosi_sync <= {mosi_sync[0], mosi};
            sclk_last <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_last;
    assign sclk_fall = ~sclk_sync[1] & sclk_last;
    assign cs_active = ~cs_sync[1];
    assign rx_next   = {rx_sreg[6:0], mosi_sync[1]}; // mode 0, sample on rise

    // frame boundaries
    assign addr_done = cs_active && (state == audio_spi_pkg::ADDR) && sclk_rise
                       && (bit_cnt == LAST_ADDR_BIT);
    assign data_done = cs_active && (state == audio_spi_pkg::DATA) && sclk_rise
                       && (bit_cnt == LAST_BIT);

    assign miso    = tx_sreg[7];   // msb first
    assign miso_oe = cs_active;

    ////////////////////////////////////////////////////////////
    // frame sequencer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= audio_spi_pkg::IDLE;
            bit_cnt    <= '0;
            is_rd      <= 1'b0;
            tx_load    <= 1'b0;
            tx_sreg    <= '0;
            bus.rd_stb <= 1'b0;
            bus.wr_stb <= 1'b0;
        end else begin
            bus.rd_stb <= addr_done & rx_next[7];
            bus.wr_stb <= data_done & ~is_rd;
            if (!cs_active) begin
                state   <= audio_spi_pkg::IDLE;  // also aborts a partial frame
                tx_load <= 1'b0;
            end else begin
                case (state)
                    audio_spi_pkg::IDLE: begin
                        bit_cnt <= '0;
                        state   <= audio_spi_pkg::ADDR;
                    end
                    audio_spi_pkg::ADDR: begin
                        if (sclk_rise) bit_cnt <= bit_cnt + 1'b1;
                        if (addr_done) begin
                            is_rd   <= rx_next[7];
                            tx_load <= rx_next[7];
                            state   <= audio_spi_pkg::DATA;
                        end
                    end
                    audio_spi_pkg::DATA: begin
                        if (sclk_rise) bit_cnt <= bit_cnt + 1'b1;
                        if (data_done) state <= audio_spi_pkg::DONE;
                    end
                    default: ; // DONE, hold until cs_n rises
                endcase

                // read data out on falling edges
                if (is_rd && sclk_fall && state != audio_spi_pkg::ADDR) begin
                    if (tx_load) begin
                        tx_sreg <= bus.rdata; // first fall after the address byte
                        tx_load <= 1'b0;
                    end else begin
                        tx_sreg <= {tx_sreg[6:0], 1'b0};
                    end
                end
            end
        end
    end

    // shift register and captured fields
    always_ff @(posedge clk) begin
        if (sclk_rise) rx_sreg <= rx_next;
        if (addr_done) bus.addr <= rx_next[6:0];
        if (data_done) bus.wdata <= rx_next;
    end

endmodule

`default_nettype wire

// File: test/tb_audio_spi_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "audio_spi_cfg.svh"

module tb_audio_spi_top;

    typedef enum {OP_WR, OP_RD, OP_IRQ} op_t;            // irq row changes irq_in only
    typedef enum {STB_NONE, STB_COEF, STB_EQ, STB_ROT} stb_t;
    typedef struct {
        string                    name;
        op_t                      op;
        audio_spi_pkg::reg_addr_t addr;
        audio_spi_pkg::reg_data_t wdata;
        audio_spi_pkg::reg_data_t exp;   // expected read data
        stb_t                     stb;   // strobe expected once
    } row_t;

    // values on the read-only inputs
    localparam audio_spi_pkg::reg_data_t    AUD_STATUS_IN = 8'h5a;
    localparam audio_spi_pkg::reg_data_t    I2S_CNT_IN    = 8'h21;
    localparam audio_spi_pkg::reg_data_t    SRAM_RD_IN    = 8'hc3;
    localparam audio_spi_pkg::reg_data_t    MPIO_RD_IN    = 8'h3c;
    localparam audio_spi_pkg::reg_data_t    ROTARY_IN     = 8'h47;
    localparam audio_spi_pkg::status_bits_t STATUS_IN     = 7'h25;
    localparam audio_spi_pkg::reg_data_t    IRQ_NEW       = 8'hc6;

    logic clk;
    logic arst_n;
    logic sclk;
    logic cs_n;
    logic mosi;
    logic miso;
    logic miso_oe;
    audio_spi_pkg::reg_data_t    audio_status, i2s_bit_cnt, sram_rd_data, mpio_rd_data;
    audio_spi_pkg::reg_data_t    rotary_count, irq_in;
    audio_spi_pkg::status_bits_t status;
    audio_spi_pkg::reg_data_t    audio_control, coefs_per_tap, coef_select, coef_lsb;
    audio_spi_pkg::reg_data_t    coef_msb, eq_select, eq_gain_lsb, eq_gain_msb;
    audio_spi_pkg::reg_data_t    eq_scaler_lsb, eq_scaler_msb, sram_control, sram_start_addr;
    audio_spi_pkg::reg_data_t    spi_to_sram, mpio_control, spi_to_mpio, test_reg;
    logic                        coef_wr_stb, eq_wr_stb, rotary_rd_stb;

    row_t                     rows[$];
    audio_spi_pkg::reg_data_t shadow [128];  // expected value of each r/w register
    audio_spi_pkg::reg_addr_t rw_addrs [16] = '{
        `ADDR_AUD_CONTROL, `ADDR_COEFS_PER_TAP, `ADDR_COEF_SEL, `ADDR_FIR_COEF_LSB,
        `ADDR_FIR_COEF_MSB, `ADDR_SRAM_CONTROL, `ADDR_SRAM_ADDR, `ADDR_SPI_TO_SRAM,
        `ADDR_MPIO_CONTROL, `ADDR_SPI_TO_MPIO, `ADDR_EQ_SEL, `ADDR_EQ_GAIN_LSB,
        `ADDR_EQ_GAIN_MSB, `ADDR_TEST, `ADDR_EQ_SCALER_LSB, `ADDR_EQ_SCALER_MSB
    };
    logic [15:0]              lfsr = 16'd14;
    int                       cycles = 0;
    int                       cycle_limit = 0;  // set once the table is built
    int                       coef_cnt, eq_cnt, rot_cnt;
    audio_spi_pkg::reg_data_t coef_lsb_seen, coef_msb_seen, eq_lsb_seen, eq_msb_seen;

    tb_clk_gen i_clk_gen (.clk(clk), .arst_n(arst_n));

    audio_spi_top i_dut (.*);

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_data(input string name, input audio_spi_pkg::reg_data_t exp,
                              input audio_spi_pkg::reg_data_t act);
        if (act !== exp) begin
            $display("Error: %s expected 0x%02h actual 0x%02h", name, exp, act);
            $display("Test failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            $display("Test failed");
            $fatal(1, "strobe or flag mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Error: %s expected %0d pulses actual %0d", name, exp, act);
            $display("Test failed");
            $fatal(1, "pulse count mismatch");
        end
    endtask

    // galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic take_byte(output audio_spi_pkg::reg_data_t b);
        b = '0;
        for (int k = 0; k < 8; k++) begin
            lfsr = lfsr_next(lfsr);          // one step per bit
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    function automatic bit is_rw(input audio_spi_pkg::reg_addr_t a);
        foreach (rw_addrs[i]) begin
            if (rw_addrs[i] == a) return 1'b1;
        end
        return 1'b0;
    endfunction

    // dut output port behind each r/w address
    function automatic audio_spi_pkg::reg_data_t port_value(input audio_spi_pkg::reg_addr_t a);
        case (a)
            `ADDR_AUD_CONTROL:   return audio_control;
            `ADDR_COEFS_PER_TAP: return coefs_per_tap;
            `ADDR_COEF_SEL:      return coef_select;
            `ADDR_FIR_COEF_LSB:  return coef_lsb;
            `ADDR_FIR_COEF_MSB:  return coef_msb;
            `ADDR_SRAM_CONTROL:  return sram_control;
            `ADDR_SRAM_ADDR:     return sram_start_addr;
            `ADDR_SPI_TO_SRAM:   return spi_to_sram;
            `ADDR_MPIO_CONTROL:  return mpio_control;
            `ADDR_SPI_TO_MPIO:   return spi_to_mpio;
            `ADDR_EQ_SEL:        return eq_select;
            `ADDR_EQ_GAIN_LSB:   return eq_gain_lsb;
            `ADDR_EQ_GAIN_MSB:   return eq_gain_msb;
            `ADDR_TEST:          return test_reg;
            `ADDR_EQ_SCALER_LSB: return eq_scaler_lsb;
            `ADDR_EQ_SCALER_MSB: return eq_scaler_msb;
            default:             return '0;
        endcase
    endfunction

    task automatic check_ports(input string name);
        foreach (rw_addrs[i]) begin
            check_data($sformatf("%s port %02h", name, rw_addrs[i]), shadow[rw_addrs[i]],
                       port_value(rw_addrs[i]));
        end
    endtask

    task automatic add_row(input string name, input op_t op, input audio_spi_pkg::reg_addr_t addr,
                           input audio_spi_pkg::reg_data_t wdata,
                           input audio_spi_pkg::reg_data_t exp, input stb_t stb);
        row_t r;
        r = '{name, op, addr, wdata, exp, stb};
        rows.push_back(r);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////
    task automatic build_table();
        audio_spi_pkg::reg_data_t b;
        stb_t                     s;
        foreach (rw_addrs[i]) begin
            take_byte(b);
            s = (rw_addrs[i] == `ADDR_FIR_COEF_LSB) ? STB_COEF :
                (rw_addrs[i] == `ADDR_EQ_GAIN_LSB)  ? STB_EQ : STB_NONE;
            add_row($sformatf("wr_%02h", rw_addrs[i]), OP_WR, rw_addrs[i], b, '0, s);
            add_row($sformatf("rd_%02h", rw_addrs[i]), OP_RD, rw_addrs[i], '0, b, STB_NONE);
        end
        take_byte(b);
        add_row("coef_msb", OP_WR, `ADDR_FIR_COEF_MSB, b, '0, STB_NONE);  // no commit
        take_byte(b);
        add_row("coef_lsb", OP_WR, `ADDR_FIR_COEF_LSB, b, '0, STB_COEF);
        take_byte(b);
        add_row("eq_gain_msb", OP_WR, `ADDR_EQ_GAIN_MSB, b, '0, STB_NONE);
        take_byte(b);
        add_row("eq_gain_lsb", OP_WR, `ADDR_EQ_GAIN_LSB, b, '0, STB_EQ);
        // read-only inputs, a write must not land anywhere
        add_row("rd_aud_status", OP_RD, `ADDR_AUD_STATUS, '0, AUD_STATUS_IN, STB_NONE);
        add_row("wr_aud_status", OP_WR, `ADDR_AUD_STATUS, 8'hff, '0, STB_NONE);
        add_row("rd_aud_status_2", OP_RD, `ADDR_AUD_STATUS, '0, AUD_STATUS_IN, STB_NONE);
        add_row("rd_sram_to_spi", OP_RD, `ADDR_SRAM_TO_SPI, '0, SRAM_RD_IN, STB_NONE);
        add_row("rd_mpio_to_spi", OP_RD, `ADDR_MPIO_TO_SPI, '0, MPIO_RD_IN, STB_NONE);
        add_row("wr_i2s_bit_cnt", OP_WR, `ADDR_I2S_BIT_CNT, 8'h0f, '0, STB_NONE);
        add_row("rd_i2s_bit_cnt", OP_RD, `ADDR_I2S_BIT_CNT, '0, I2S_CNT_IN, STB_NONE);
        add_row("rd_rotary_1", OP_RD, `ADDR_ROTARY, '0, ROTARY_IN, STB_ROT);
        add_row("rd_rotary_2", OP_RD, `ADDR_ROTARY, '0, ROTARY_IN, STB_ROT);
        add_row("rd_status_idle", OP_RD, `ADDR_STATUS, '0, {1'b0, STATUS_IN}, STB_NONE);
        // holes in the map
        add_row("wr_hole_06", OP_WR, 7'h06, 8'h12, '0, STB_NONE);
        add_row("rd_hole_06", OP_RD, 7'h06, '0, `UNMAPPED_READ, STB_NONE);
        add_row("rd_hole_15", OP_RD, 7'h15, '0, `UNMAPPED_READ, STB_NONE);
        add_row("rd_hole_7f", OP_RD, 7'h7f, '0, `UNMAPPED_READ, STB_NONE);
        // interrupt capture and clear on read
        add_row("irq_change", OP_IRQ, '0, IRQ_NEW, '0, STB_NONE);
        add_row("rd_status_irq", OP_RD, `ADDR_STATUS, '0, {1'b1, STATUS_IN}, STB_NONE);
        add_row("rd_irq_first", OP_RD, `ADDR_INTERRUPT, '0, IRQ_NEW, STB_NONE);
        add_row("rd_irq_second", OP_RD, `ADDR_INTERRUPT, '0, 8'h00, STB_NONE);
        add_row("rd_status_clear", OP_RD, `ADDR_STATUS, '0, {1'b0, STATUS_IN}, STB_NONE);
    endtask

    ////////////////////////////////////////////////////////////
    // spi master, mode 0, 5 clk per sclk phase
    ////////////////////////////////////////////////////////////
    task automatic spi_transfer(input string name, input logic rd,
                                input audio_spi_pkg::reg_addr_t addr,
                                input audio_spi_pkg::reg_data_t wdata,
                                output audio_spi_pkg::reg_data_t rdata);
        logic [15:0] tx;
        tx    = {rd, addr, wdata};
        rdata = '0;
        cs_n <= 1'b0;                            // called on a rising edge
        for (int i = 15; i >= 0; i--) begin
            sclk <= 1'b0;
            mosi <= tx[i];
            repeat (4) @(posedge clk);
            @(negedge clk);                      // miso settled after the fall
            if (i == 15) check_bit({name, " miso_oe"}, 1'b1, miso_oe);
            if (i < 8) rdata[i] = miso;
            @(posedge clk);
            sclk <= 1'b1;
            repeat (5) @(posedge clk);
        end
        sclk <= 1'b0;
        repeat (3) @(posedge clk);
        cs_n <= 1'b1;
        repeat (6) @(posedge clk);
        @(negedge clk);
        check_bit({name, " miso_oe idle"}, 1'b0, miso_oe);
    endtask

    task automatic apply_row(input row_t r);
        audio_spi_pkg::reg_data_t rd;
        @(posedge clk);
        if (r.op == OP_IRQ) begin
            irq_in <= r.wdata;
            repeat (4) @(posedge clk);
        end else begin
            coef_cnt = 0;
            eq_cnt   = 0;
            rot_cnt  = 0;
            spi_transfer(r.name, r.op == OP_RD, r.addr, r.wdata, rd);
            if (r.op == OP_WR && is_rw(r.addr)) shadow[r.addr] = r.wdata;
            if (r.op == OP_RD) check_data(r.name, r.exp, rd);
            check_count({r.name, " coef_wr_stb"}, int'(r.stb == STB_COEF), coef_cnt);
            check_count({r.name, " eq_wr_stb"}, int'(r.stb == STB_EQ), eq_cnt);
            check_count({r.name, " rotary_rd_stb"}, int'(r.stb == STB_ROT), rot_cnt);
            if (r.stb == STB_COEF) begin                 // both halves at commit
                check_data({r.name, " lsb at pulse"}, shadow[`ADDR_FIR_COEF_LSB], coef_lsb_seen);
                check_data({r.name, " msb at pulse"}, shadow[`ADDR_FIR_COEF_MSB], coef_msb_seen);
            end
            if (r.stb == STB_EQ) begin
                check_data({r.name, " lsb at pulse"}, shadow[`ADDR_EQ_GAIN_LSB], eq_lsb_seen);
                check_data({r.name, " msb at pulse"}, shadow[`ADDR_EQ_GAIN_MSB], eq_msb_seen);
            end
            check_ports(r.name);
        end
    endtask

    // strobe pulse counters, sampled mid cycle
    always @(negedge clk) begin
        if (coef_wr_stb) begin
            coef_cnt      = coef_cnt + 1;
            coef_lsb_seen = coef_lsb;
            coef_msb_seen = coef_msb;
        end
        if (eq_wr_stb) begin
            eq_cnt      = eq_cnt + 1;
            eq_lsb_seen = eq_gain_lsb;
            eq_msb_seen = eq_gain_msb;
        end
        if (rotary_rd_stb) rot_cnt = rot_cnt + 1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: no result after %0d clk cycles", cycles);
            $display("Test failed");
            $fatal(1, "simulation stopped at the cycle limit");
        end
    end

    initial begin
        sclk         <= 1'b0;
        cs_n         <= 1'b1;
        mosi         <= 1'b0;
        audio_status <= AUD_STATUS_IN;
        i2s_bit_cnt  <= I2S_CNT_IN;
        sram_rd_data <= SRAM_RD_IN;
        mpio_rd_data <= MPIO_RD_IN;
        rotary_count <= ROTARY_IN;
        status       <= STATUS_IN;
        irq_in       <= '0;
        foreach (shadow[i]) shadow[i] = '0;
        build_table();
        cycle_limit = rows.size() * 200 + 200;  // one frame is about 172 clk
        @(posedge arst_n);
        @(negedge clk);
        check_ports("reset");
        check_bit("reset coef_wr_stb", 1'b0, coef_wr_stb);
        check_bit("reset eq_wr_stb", 1'b0, eq_wr_stb);
        check_bit("reset rotary_rd_stb", 1'b0, rotary_rd_stb);
        check_bit("reset miso_oe", 1'b0, miso_oe);
        foreach (rows[i]) apply_row(rows[i]);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    localparam realtime HALF_PERIOD = 2.0;  // 4 ns clk

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset held for two rising edges
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire
